// File: files.f
hdl/rv_pkg.sv
hdl/regfile.sv
hdl/fetch_ctrl.sv
hdl/decoder.sv
hdl/exec_unit.sv
hdl/data_bus_ctrl.sv
hdl/rv_core.sv
testbench/rv_ref_model.sv
testbench/tb_rv_core.sv

// File: testbench/tb_rv_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_rv_core;

    localparam logic [31:0] RESET_VECTOR = 32'h0000_1000;
    localparam int          PROG_LEN     = 64;
    localparam int          TOTAL_LEN    = 96;      // Program, register dump and end loop
    localparam int          CYCLE_LIMIT  = TOTAL_LEN * 12 + 50;
    localparam logic [31:0] DUMP_BASE    = 32'h0000_0300;
    localparam logic [31:0] END_ADDR     = RESET_VECTOR + 32'((TOTAL_LEN - 1) * 4);

    logic        inst_bus;
    logic        rst_n;
    logic        ib_cyc;
    logic        ib_stb;
    logic [31:0] ib_adr;
    logic [31:0] ib_dat_i;
    logic        ib_ack;
    logic        db_cyc;
    logic        db_stb;
    logic        db_we;
    logic [3:0]  db_sel;
    logic [31:0] db_adr;
    logic [31:0] db_dat_o;
    logic [31:0] db_dat_i;
    logic        db_ack;

    logic [31:0] imem       [0:127];
    logic [31:0] dmem       [0:255];
    logic [31:0] dmem_init  [0:255];
    logic [31:0] dmem_pass0 [0:255];
    logic [31:0] lfsr_state;
    int          error_count;
    int          check_count;
    logic        timed_out;
    logic        end_seen;
    logic        first_fetch;
    logic        mem_pending;   // Model expects a data access for this instruction
    logic        ib_busy;
    logic        db_busy;
    int          ib_wait;
    int          db_wait;
    logic [31:0] ib_hold_adr;
    logic [31:0] db_hold_adr;
    logic [3:0]  db_hold_sel;
    logic        db_hold_we;
    logic [31:0] db_hold_dat;

    rv_core #(.RESET_VECTOR(RESET_VECTOR)) UUT (.*);

    rv_ref_model ref_model ();

    initial
    begin
        inst_bus = 1'b0;
        forever #50 inst_bus = ~inst_bus;
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic lfsr_bit();
        logic fb;
        fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    // Store with base x0
    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [2:0] f3);
        return {imm[11:5], rs2, 5'd0, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] imem_word(input logic [31:0] adr);
        logic [31:0] off;
        off = adr - RESET_VECTOR;
        if (off < 32'd512)
            return imem[off[8:2]];
        else
            return 32'h0000_0013;   // NOP outside the program
    endfunction

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("ERROR at %0t ns: %s, expected %h, got %h", $time, what, expected, actual);
        end
    endtask

    task automatic gen_program();
        logic [2:0]  kind;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [11:0] imm;
        logic [19:0] u20;
        for (int i = 0; i < 128; i++)
        begin
            imem[i] = 32'h0000_0013;
        end
        for (int i = 0; i < PROG_LEN; i++)
        begin
            kind = 3'(rand_bits(3));
            rd   = 5'(rand_bits(5));
            rs1  = 5'(rand_bits(5));
            u20  = 20'(rand_bits(20));
            if (kind == 3'd4 && i > PROG_LEN - 4)
                kind = 3'd0;    // Jump must land inside the program
            case (kind)
                3'd2: imem[i] = {u20, rd, 7'b0110111};
                3'd3: imem[i] = {u20, rd, 7'b0010111};
                3'd4: imem[i] = enc_j(21'(4 * (rand_bits(2) + 1)), rd);
                3'd5:
                begin
                    f3 = 3'(rand_bits(3) % 5);
                    if (f3 > 3'd2)
                        f3 = f3 + 3'd1;     // B H W BU HU
                    imem[i] = enc_i(12'h200 + 12'(rand_bits(8)), 5'd0, f3, rd, 7'b0000011);
                end
                3'd6:
                begin
                    f3      = 3'(rand_bits(2) % 3);
                    imem[i] = enc_s(12'h200 + 12'(rand_bits(8)), rs1, f3);
                end
                default:
                begin
                    f3  = 3'(rand_bits(3));
                    imm = 12'(rand_bits(12));
                    if (f3 == 3'b001)
                        imm = {7'b0, imm[4:0]};
                    else if (f3 == 3'b101)
                        imm = {1'b0, imm[10], 5'b0, imm[4:0]};
                    imem[i] = enc_i(imm, rs1, f3, rd, 7'b0010011);
                end
            endcase
        end
        for (int r = 1; r < 32; r++)
        begin
            imem[PROG_LEN + r - 1] = enc_s(12'(DUMP_BASE + 4 * (r - 1)), 5'(r), 3'b010);
        end
        imem[TOTAL_LEN - 1] = enc_j(21'd0, 5'd0);   // End loop
        for (int a = 0; a < 256; a++)
        begin
            dmem_init[a] = rand_bits(32);
        end
    endtask

    // Both slave models run once per cycle 5 ns after the rising edge
    task automatic serve_buses(input int pass);
        logic [7:0] idx;
        check_equal(ib_stb, ib_cyc, "ib_stb follows ib_cyc");
        check_equal(db_stb, db_cyc, "db_stb follows db_cyc");
        if (ib_cyc && ib_stb)
        begin
            if (!ib_busy)
            begin
                ib_busy     = 1'b1;
                ib_hold_adr = ib_adr;
                ib_wait     = (pass == 0) ? 0 : int'(rand_bits(2));
                if (first_fetch)
                    check_equal(ib_adr, RESET_VECTOR, "first fetch address");
                first_fetch = 1'b0;
                check_equal(ib_adr, ref_model.pc, "fetch address");
                if (mem_pending)
                begin
                    $display("Memory instruction retired without a data bus access at %0t", $time);
                    error_count++;
                end
                mem_pending = 1'b0;
                if (ib_adr == END_ADDR)
                    end_seen = 1'b1;
                else
                begin
                    ref_model.step(imem_word(ref_model.pc));
                    mem_pending = ref_model.mem_acc;
                end
            end
            else
                check_equal(ib_adr, ib_hold_adr, "ib_adr held until ack");
            if (ib_wait == 0)
            begin
                ib_ack   = 1'b1;
                ib_dat_i = imem_word(ib_hold_adr);
                ib_busy  = 1'b0;
            end
            else
            begin
                ib_ack = 1'b0;
                ib_wait--;
            end
        end
        else
        begin
            if (ib_busy)
            begin
                $display("Instruction bus request dropped before ack at %0t", $time);
                error_count++;
            end
            ib_busy = 1'b0;
            ib_ack  = 1'b0;
        end

        if (db_cyc && db_stb)
        begin
            if (!db_busy)
            begin
                if (!mem_pending)
                begin
                    $display("Data bus request without a memory instruction at %0t", $time);
                    error_count++;
                end
                mem_pending = 1'b0;
                db_busy     = 1'b1;
                db_hold_adr = db_adr;
                db_hold_sel = db_sel;
                db_hold_we  = db_we;
                db_hold_dat = db_dat_o;
                db_wait     = (pass == 0) ? 0 : int'(rand_bits(2));
                check_equal(db_adr, ref_model.mem_adr, "data address");
                check_equal(db_sel, ref_model.mem_sel, "byte lane select");
                check_equal(db_we, ref_model.mem_we, "write enable");
                if (ref_model.mem_we)
                    check_equal(db_dat_o, ref_model.mem_dat, "store data");
            end
            else
            begin
                check_equal(db_adr, db_hold_adr, "db_adr held until ack");
                check_equal(db_sel, db_hold_sel, "db_sel held until ack");
                check_equal(db_we, db_hold_we, "db_we held until ack");
                check_equal(db_dat_o, db_hold_dat, "db_dat_o held until ack");
            end
            if (db_wait == 0)
            begin
                idx = db_hold_adr[9:2];
                if (db_hold_we)
                begin
                    for (int b = 0; b < 4; b++)
                    begin
                        if (db_hold_sel[b])
                            dmem[idx][8*b +: 8] = db_hold_dat[8*b +: 8];
                    end
                end
                db_ack   = 1'b1;
                db_dat_i = dmem[idx];
                db_busy  = 1'b0;
            end
            else
            begin
                db_ack = 1'b0;
                db_wait--;
            end
        end
        else
        begin
            if (db_busy)
            begin
                $display("Data bus request dropped before ack at %0t", $time);
                error_count++;
            end
            db_busy = 1'b0;
            db_ack  = 1'b0;
        end
    endtask

    // Pass 0 acks at once and pass 1 adds random wait cycles
    task automatic run_pass(input int pass);
        int cycles;
        for (int a = 0; a < 256; a++)
        begin
            dmem[a]           = dmem_init[a];
            ref_model.dmem[a] = dmem_init[a];
        end
        ref_model.reset_state(RESET_VECTOR);
        ib_busy     = 1'b0;
        db_busy     = 1'b0;
        end_seen    = 1'b0;
        first_fetch = 1'b1;
        mem_pending = 1'b0;
        rst_n       = 1'b0;
        ib_ack      = 1'b0;
        db_ack      = 1'b0;
        repeat (4) @(posedge inst_bus);
        #5;
        rst_n  = 1'b1;
        cycles = 0;
        while (!end_seen && cycles < CYCLE_LIMIT)
        begin
            @(posedge inst_bus);
            #5;
            serve_buses(pass);
            cycles++;
        end
        if (!end_seen)
        begin
            $display("Timeout: the core never reached the end loop in pass %0d", pass);
            timed_out = 1'b1;
        end
        else
        begin
            for (int r = 1; r < 32; r++)
            begin
                check_equal(dmem[(DUMP_BASE >> 2) + r - 1], ref_model.x[r],
                            $sformatf("dump of x%0d in pass %0d", r, pass));
            end
            for (int a = 0; a < 256; a++)
            begin
                check_equal(dmem[a], ref_model.dmem[a], $sformatf("data word %0d", a));
                if (pass == 0)
                    dmem_pass0[a] = dmem[a];
                else
                    check_equal(dmem[a], dmem_pass0[a], "data word against zero-wait pass");
            end
        end
    endtask

    initial
    begin
        rst_n       = 1'b0;
        ib_ack      = 1'b0;
        ib_dat_i    = '0;
        db_ack      = 1'b0;
        db_dat_i    = '0;
        lfsr_state  = 32'hd50630e5;
        error_count = 0;
        check_count = 0;
        timed_out   = 1'b0;
        gen_program();
        for (int pass = 0; pass < 2; pass++)
        begin
            if (!timed_out)
                run_pass(pass);
        end
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0 && !timed_out)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/rv_ref_model.sv
`timescale 1ns/1ns
`default_nettype none

// Instruction-level model of the supported RV32I subset stepped once per instruction
module rv_ref_model;

    logic [31:0] x    [0:31];
    logic [31:0] dmem [0:255];    // Word copy of the data memory
    logic [31:0] pc;
    logic        mem_acc;         // Last step made a data access
    logic        mem_we;
    logic [31:0] mem_adr;
    logic [3:0]  mem_sel;
    logic [31:0] mem_dat;

    task automatic reset_state(input logic [31:0] start);
        for (int r = 0; r < 32; r++)
        begin
            x[r] = '0;
        end
        pc      = start;
        mem_acc = 1'b0;
        mem_we  = 1'b0;
    endtask

    task automatic step(input logic [31:0] ins);
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] src;
        logic [31:0] res;
        logic [31:0] addr;
        logic [31:0] word;
        logic [31:0] next_pc;
        logic        wr;
        logic [4:0]  sh;
        imm_i   = {{20{ins[31]}}, ins[31:20]};
        imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        src     = x[ins[19:15]];
        sh      = ins[24:20];
        next_pc = pc + 32'd4;
        res     = '0;
        wr      = 1'b0;
        mem_acc = 1'b0;
        mem_we  = 1'b0;
        case (ins[6:0])
            7'b0010011:    // Register-immediate ALU
            begin
                wr = 1'b1;
                case (ins[14:12])
                    3'd0: res = src + imm_i;
                    3'd1: res = src << sh;
                    3'd2: res = ($signed(src) < $signed(imm_i)) ? 32'd1 : 32'd0;
                    3'd3: res = (src < imm_i) ? 32'd1 : 32'd0;
                    3'd4: res = src ^ imm_i;
                    3'd5:
                    begin
                        if (ins[30])
                            res = $signed(src) >>> sh;
                        else
                            res = src >> sh;
                    end
                    3'd6: res = src | imm_i;
                    default: res = src & imm_i;
                endcase
            end
            7'b0110111:
            begin
                wr  = 1'b1;
                res = {ins[31:12], 12'h000};
            end
            7'b0010111:
            begin
                wr  = 1'b1;
                res = pc + {ins[31:12], 12'h000};
            end
            7'b1101111:
            begin
                wr      = 1'b1;
                res     = pc + 32'd4;
                next_pc = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            7'b0000011:
            begin
                wr      = 1'b1;
                mem_acc = 1'b1;
                addr    = src + imm_i;
                word    = dmem[addr[9:2]];
                case (ins[13:12])
                    2'd0:
                    begin
                        mem_sel = 4'b0001 << addr[1:0];
                        res     = word >> (8 * addr[1:0]);
                        res     = ins[14] ? {24'h0, res[7:0]} : {{24{res[7]}}, res[7:0]};
                    end
                    2'd1:
                    begin
                        mem_sel = addr[1] ? 4'b1100 : 4'b0011;    // Bit 0 is ignored
                        res     = addr[1] ? word >> 16 : word;
                        res     = ins[14] ? {16'h0, res[15:0]} : {{16{res[15]}}, res[15:0]};
                    end
                    default:
                    begin
                        mem_sel = 4'b1111;
                        res     = word;
                    end
                endcase
                mem_adr = {addr[31:2], 2'b00};
            end
            7'b0100011:
            begin
                mem_acc = 1'b1;
                mem_we  = 1'b1;
                addr    = src + imm_s;
                word    = x[ins[24:20]];
                mem_adr = {addr[31:2], 2'b00};
                case (ins[13:12])
                    2'd0:
                    begin
                        mem_sel = 4'b0001 << addr[1:0];
                        mem_dat = {4{word[7:0]}};
                    end
                    2'd1:
                    begin
                        mem_sel = addr[1] ? 4'b1100 : 4'b0011;
                        mem_dat = {2{word[15:0]}};
                    end
                    default:
                    begin
                        mem_sel = 4'b1111;
                        mem_dat = word;
                    end
                endcase
                for (int b = 0; b < 4; b++)
                begin
                    if (mem_sel[b])
                        dmem[addr[9:2]][8*b +: 8] = mem_dat[8*b +: 8];
                end
            end
            default:
            begin
                // Other opcodes retire without effect
            end
        endcase
        if (wr && ins[11:7] != 5'd0)
            x[ins[11:7]] = res;
        pc = next_pc;
    endtask

endmodule

`default_nettype wire

// File: hdl/rv_core.sv
`timescale 1ns/1ns
`default_nettype none

module rv_core import rv_pkg::*;
#(
    parameter logic [31:0] RESET_VECTOR = 32'h0000_0000
)
(
    input  logic            inst_bus,
    input  logic            rst_n,
    // Instruction bus, read only
    output logic            ib_cyc,
    output logic            ib_stb,
    output logic [XLEN-1:0] ib_adr,
    input  logic [XLEN-1:0] ib_dat_i,
    input  logic            ib_ack,
    // Data bus
    output logic            db_cyc,
    output logic            db_stb,
    output logic            db_we,
    output logic [3:0]      db_sel,
    output logic [XLEN-1:0] db_adr,
    output logic [XLEN-1:0] db_dat_o,
    input  logic [XLEN-1:0] db_dat_i,
    input  logic            db_ack
);

    instr_u                instr;
    logic [XLEN-1:0]       pc;
    logic                  execute;

    logic [REG_ADDR_W-1:0] rd_addr;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       imm;
    logic [2:0]            alu_f3;
    logic                  alu_f7b5;
    logic [1:0]            wb_src;
    logic                  wb_en;
    logic                  mem_rd;
    logic                  mem_wr;
    logic [2:0]            mem_f3;
    logic                  jump;

    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic                  wr_en;
    logic [XLEN-1:0]       wr_data;
    logic [XLEN-1:0]       jump_target;
    logic                  stall;
    logic [XLEN-1:0]       load_data;

    fetch_ctrl #(.RESET_VECTOR(RESET_VECTOR)) u_fetch (.*);

    decoder u_decoder (.*);

    regfile u_regfile (.*);

    exec_unit u_exec (.*);

    data_bus_ctrl u_dbus (.*);

endmodule

`default_nettype wire

// File: hdl/data_bus_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module data_bus_ctrl import rv_pkg::*;
(
    input  logic            inst_bus,
    input  logic            rst_n,
    input  logic            mem_rd,
    input  logic            mem_wr,
    input  logic [2:0]      mem_f3,
    input  logic [XLEN-1:0] rs1_data,
    input  logic [XLEN-1:0] rs2_data,
    input  logic [XLEN-1:0] imm,
    input  logic [XLEN-1:0] db_dat_i,
    input  logic            db_ack,
    output logic            db_cyc,
    output logic            db_stb,
    output logic            db_we,
    output logic [3:0]      db_sel,
    output logic [XLEN-1:0] db_adr,
    output logic [XLEN-1:0] db_dat_o,
    output logic            stall,
    output logic [XLEN-1:0] load_data
);

    logic [XLEN-1:0] addr;
    logic            req;
    logic            done;
    logic [7:0]      ld_byte;
    logic [15:0]     ld_half;

    assign addr   = rs1_data + imm;
    assign db_adr = {addr[XLEN-1:2], 2'b00};

    // Done blocks a second request in the cycle after ack
    assign req      = (mem_rd | mem_wr) & ~done;
    assign db_cyc   = req;
    assign db_stb   = req;
    assign db_we    = req & mem_wr;
    assign stall    = req & ~db_ack;

    always_ff @(posedge inst_bus)
    begin
        if (!rst_n)
        begin
            done <= 1'b0;
        end
        else
        begin
            done <= req & db_ack;
        end
    end

    // Byte lanes and replicated store data
    always_comb
    begin
        case (mem_f3[1:0])
            2'b00:   db_sel = 4'b0001 << addr[1:0];
            2'b01:   db_sel = addr[1] ? 4'b1100 : 4'b0011;
            default: db_sel = 4'b1111;
        endcase
        case (mem_f3[1:0])
            2'b00:   db_dat_o = {4{rs2_data[7:0]}};
            2'b01:   db_dat_o = {2{rs2_data[15:0]}};
            default: db_dat_o = rs2_data;
        endcase
    end

    assign ld_byte = db_dat_i[{addr[1:0], 3'b000} +: 8];
    assign ld_half = addr[1] ? db_dat_i[31:16] : db_dat_i[15:0];

    always_comb
    begin
        case (mem_f3)
            F3_B:    load_data = {{24{ld_byte[7]}}, ld_byte};
            F3_BU:   load_data = {24'h000000, ld_byte};
            F3_H:    load_data = {{16{ld_half[15]}}, ld_half};
            F3_HU:   load_data = {16'h0000, ld_half};
            default: load_data = db_dat_i;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/exec_unit.sv
`timescale 1ns/1ns
`default_nettype none

module exec_unit import rv_pkg::*;
(
    input  logic [XLEN-1:0] rs1_data,
    input  logic [XLEN-1:0] imm,
    input  logic [XLEN-1:0] pc,
    input  logic [2:0]      alu_f3,
    input  logic            alu_f7b5,
    input  logic [1:0]      wb_src,
    input  logic            wb_en,
    input  logic            mem_rd,
    input  logic [XLEN-1:0] load_data,
    input  logic            stall,
    output logic            wr_en,
    output logic [XLEN-1:0] wr_data,
    output logic [XLEN-1:0] jump_target
);

    logic [XLEN-1:0] alu_res;
    logic [XLEN-1:0] pc_imm;
    logic [XLEN-1:0] wb_val;
    logic [4:0]      shamt;

    assign shamt  = imm[4:0];
    assign pc_imm = pc + imm;     // Shared by AUIPC and the JAL target

    // Immediate ALU
    always_comb
    begin
        case (alu_f3)
            F3_ADD:  alu_res = rs1_data + imm;
            F3_SLT:  alu_res = {{(XLEN-1){1'b0}}, $signed(rs1_data) < $signed(imm)};
            F3_SLTU: alu_res = {{(XLEN-1){1'b0}}, rs1_data < imm};
            F3_XOR:  alu_res = rs1_data ^ imm;
            F3_OR:   alu_res = rs1_data | imm;
            F3_AND:  alu_res = rs1_data & imm;
            F3_SLL:  alu_res = rs1_data << shamt;
            F3_SR:
            begin
                if (alu_f7b5)
                begin
                    alu_res = $signed(rs1_data) >>> shamt;
                end
                else
                begin
                    alu_res = rs1_data >> shamt;
                end
            end
            default: alu_res = '0;
        endcase
    end

    always_comb
    begin
        case (wb_src)
            WB_UIMM:  wb_val = imm;
            WB_AUIPC: wb_val = pc_imm;
            WB_LINK:  wb_val = pc + XLEN'(4);   // Return address
            default:  wb_val = alu_res;
        endcase
    end

    // Loads write only once the data bus acknowledges
    assign wr_en       = (wb_en | mem_rd) & ~stall;
    assign wr_data     = mem_rd ? load_data : wb_val;
    assign jump_target = pc_imm;

endmodule

`default_nettype wire

// File: hdl/decoder.sv
`timescale 1ns/1ns
`default_nettype none

module decoder import rv_pkg::*;
(
    input  instr_u                instr,
    input  logic                  execute,
    output logic [REG_ADDR_W-1:0] rd_addr,
    output logic [REG_ADDR_W-1:0] rs1_addr,
    output logic [REG_ADDR_W-1:0] rs2_addr,
    output logic [XLEN-1:0]       imm,
    output logic [2:0]            alu_f3,
    output logic                  alu_f7b5,
    output logic [1:0]            wb_src,
    output logic                  wb_en,
    output logic                  mem_rd,
    output logic                  mem_wr,
    output logic [2:0]            mem_f3,
    output logic                  jump
);

    logic [XLEN-1:0] i_imm;
    logic [XLEN-1:0] s_imm;
    logic [XLEN-1:0] u_imm;
    logic [XLEN-1:0] j_imm;
    logic [19:0]     raw20;

    assign raw20 = instr.uj_fmt.imm20;

    assign i_imm = {{20{instr.i_fmt.imm12[11]}}, instr.i_fmt.imm12};
    assign s_imm = {{20{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};
    assign u_imm = {raw20, 12'h000};
    // J order is imm[20|10:1|11|19:12] in bits 31:12
    assign j_imm = {{11{raw20[19]}}, raw20[19], raw20[7:0], raw20[8], raw20[18:9], 1'b0};

    always_comb
    begin
        rd_addr  = '0;
        rs1_addr = '0;
        rs2_addr = '0;
        imm      = '0;
        alu_f3   = F3_ADD;
        alu_f7b5 = 1'b0;
        wb_src   = WB_ALU;
        wb_en    = 1'b0;
        mem_rd   = 1'b0;
        mem_wr   = 1'b0;
        mem_f3   = F3_B;
        jump     = 1'b0;
        if (execute)
        begin
            case (instr.i_fmt.opcode)
                OP_IMM:
                begin
                    rd_addr  = instr.i_fmt.rd;
                    rs1_addr = instr.i_fmt.rs1;
                    imm      = i_imm;
                    alu_f3   = instr.i_fmt.funct3;
                    // Bit 30 only matters for right shifts
                    alu_f7b5 = (instr.i_fmt.funct3 == F3_SR) && instr.i_fmt.imm12[10];
                    wb_en    = 1'b1;
                end
                OP_LUI, OP_AUIPC:
                begin
                    rd_addr = instr.uj_fmt.rd;
                    imm     = u_imm;
                    wb_src  = (instr.uj_fmt.opcode == OP_LUI) ? WB_UIMM : WB_AUIPC;
                    wb_en   = 1'b1;
                end
                OP_JAL:
                begin
                    rd_addr = instr.uj_fmt.rd;
                    imm     = j_imm;
                    wb_src  = WB_LINK;
                    wb_en   = 1'b1;
                    jump    = 1'b1;
                end
                OP_LOAD:
                begin
                    rd_addr  = instr.i_fmt.rd;
                    rs1_addr = instr.i_fmt.rs1;
                    imm      = i_imm;
                    mem_rd   = 1'b1;
                    mem_f3   = instr.i_fmt.funct3;
                end
                OP_STORE:
                begin
                    rs1_addr = instr.s_fmt.rs1;
                    rs2_addr = instr.s_fmt.rs2;
                    imm      = s_imm;
                    mem_wr   = 1'b1;
                    mem_f3   = instr.s_fmt.funct3;
                end
                default:
                begin
                    // Anything else retires as a no-op
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/fetch_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_ctrl import rv_pkg::*;
#(
    parameter logic [31:0] RESET_VECTOR = 32'h0000_0000
)
(
    input  logic            inst_bus,
    input  logic            rst_n,
    input  logic [XLEN-1:0] ib_dat_i,
    input  logic            ib_ack,
    input  logic            stall,
    input  logic            jump,
    input  logic [XLEN-1:0] jump_target,
    output logic            ib_cyc,
    output logic            ib_stb,
    output logic [XLEN-1:0] ib_adr,
    output instr_u          instr,
    output logic [XLEN-1:0] pc,
    output logic            execute
);

    logic            state;
    logic [XLEN-1:0] next_pc;

    // Request stays up for the whole fetch state, so it drops right after ack
    assign ib_cyc  = (state == ST_FETCH);
    assign ib_stb  = (state == ST_FETCH);
    assign ib_adr  = pc;
    assign execute = (state == ST_EXEC);

    assign next_pc = jump ? jump_target : pc + XLEN'(4);

    // Two-state fetch machine and program counter
    always_ff @(posedge inst_bus)
    begin
        if (!rst_n)
        begin
            state <= ST_FETCH;
            pc    <= RESET_VECTOR;
        end
        else
        begin
            case (state)
                ST_FETCH:
                begin
                    if (ib_ack)
                    begin
                        state <= ST_EXEC;
                    end
                end
                ST_EXEC:
                begin
                    // Hold here while the data bus is busy
                    if (!stall)
                    begin
                        pc    <= next_pc;
                        state <= ST_FETCH;
                    end
                end
                default:
                begin
                    state <= ST_FETCH;
                end
            endcase
        end
    end

    // Instruction register
    always_ff @(posedge inst_bus)
    begin
        if (state == ST_FETCH && ib_ack)
        begin
            instr <= instr_u'(ib_dat_i);
        end
    end

endmodule

`default_nettype wire

// File: hdl/regfile.sv
`timescale 1ns/1ns
`default_nettype none

module regfile import rv_pkg::*;
(
    input  logic                  inst_bus,
    input  logic                  rst_n,
    input  logic [REG_ADDR_W-1:0] rs1_addr,
    input  logic [REG_ADDR_W-1:0] rs2_addr,
    input  logic [REG_ADDR_W-1:0] rd_addr,
    input  logic                  wr_en,
    input  logic [XLEN-1:0]       wr_data,
    output logic [XLEN-1:0]       rs1_data,
    output logic [XLEN-1:0]       rs2_data
);

    logic [XLEN-1:0] regs [1:31];   // x0 has no storage

    always_ff @(posedge inst_bus)
    begin
        if (!rst_n)
        begin
            for (int i = 1; i < 32; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wr_en && rd_addr != '0)
        begin
            regs[rd_addr] <= wr_data;
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

// File: hdl/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // Major opcodes of the supported subset
    localparam logic [6:0] OP_IMM   = 7'b0010011;
    localparam logic [6:0] OP_LUI   = 7'b0110111;
    localparam logic [6:0] OP_AUIPC = 7'b0010111;
    localparam logic [6:0] OP_JAL   = 7'b1101111;
    localparam logic [6:0] OP_LOAD  = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;

    // Access size, shared by loads and stores
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;

    // Immediate ALU operations
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;   // SRLI or SRAI by bit 30
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // Register writeback source
    localparam logic [1:0] WB_ALU   = 2'd0;
    localparam logic [1:0] WB_UIMM  = 2'd1;
    localparam logic [1:0] WB_AUIPC = 2'd2;
    localparam logic [1:0] WB_LINK  = 2'd3;

    // Fetch FSM
    localparam logic ST_FETCH = 1'b0;
    localparam logic ST_EXEC  = 1'b1;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]  imm_hi;
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  imm_lo;
        logic [6:0]  opcode;
    } s_fmt_t;

    typedef struct packed {
        logic [19:0] imm20;   // Raw bits 31:12, J order differs from U
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } uj_fmt_t;

    typedef union packed {
        i_fmt_t  i_fmt;
        s_fmt_t  s_fmt;
        uj_fmt_t uj_fmt;
    } instr_u;

endpackage

`default_nettype wire
